// ==== src/p2r_pkg.sv ====
// power2round constants and types; sizes are fixed here, all memories start at address 0
`default_nettype none

package p2r_pkg;

    // ------------------------------------------------------------------
    // arithmetic constants
    // ------------------------------------------------------------------
    localparam int Q        = 8380417;
    localparam int D        = 13;
    localparam int COEFF_W  = $clog2(Q);
    // widest t1 comes from q - 1
    localparam int T1_W     = $clog2(((Q - 1) >> D) + 1);
    // centring bound for t0, half of 2^D
    localparam int T0_BOUND = 1 << (D - 1);

    // ------------------------------------------------------------------
    // sizes of one run
    // ------------------------------------------------------------------
    localparam int NUM_COEFF    = 32;
    localparam int SK_PER_WORD  = 2;
    localparam int PK_PER_WORD  = 4;
    localparam int SK_WORDS     = NUM_COEFF / SK_PER_WORD;
    localparam int PK_WORDS     = NUM_COEFF / PK_PER_WORD;
    // memory read, unit register, packer write
    localparam int DRAIN_CYCLES = 3;

    typedef logic [COEFF_W-1:0]                coeff_t;
    typedef logic [$clog2(NUM_COEFF)-1:0]      coeff_addr_t;
    typedef logic [T1_W-1:0]                   t1_t;
    typedef logic [D-1:0]                      t0_enc_t;
    // lower-indexed coefficient in the low bits
    typedef logic [SK_PER_WORD*D-1:0]          sk_word_t;
    typedef logic [$clog2(SK_WORDS)-1:0]       sk_addr_t;
    typedef logic [PK_PER_WORD*T1_W-1:0]       pk_word_t;
    typedef logic [$clog2(PK_WORDS)-1:0]       pk_addr_t;

    typedef enum logic [1:0] {
        IDLE,
        READ,
        DRAIN,
        ACK
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== src/p2r_stream_if.sv ====
// split coefficient stream without back-pressure; every sink must accept each valid beat
`timescale 1ns/1ns
`default_nettype none

interface p2r_stream_if;

    import p2r_pkg::*;

    // one split coefficient per beat
    logic    valid;
    // set on coefficient 0 of a run
    logic    first;
    t1_t     t1;
    t0_enc_t t0_enc;

    modport source (
        output valid,
        output first,
        output t1,
        output t0_enc
    );

    // both packers listen in parallel
    modport sink (
        input valid,
        input first,
        input t1,
        input t0_enc
    );

endinterface

`default_nettype wire

// ==== src/coeff_mem.sv ====
// coefficient RAM without reset; contents are undefined until loaded, read data lags rd_en by one clock
`timescale 1ns/1ns
`default_nettype none

module coeff_mem (
    input  wire                  clk,
    input  wire                  load_en,
    input  wire p2r_pkg::coeff_addr_t load_addr,
    input  wire p2r_pkg::coeff_t load_data,
    input  wire                  rd_en,
    input  wire p2r_pkg::coeff_addr_t rd_addr,
    output p2r_pkg::coeff_t      rd_data
);

    import p2r_pkg::*;

    coeff_t mem [NUM_COEFF];

    // write port, driven from the top level
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    // registered read for the controller
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== src/power2round_unit.sv ====
// one coefficient per clock, input must already be reduced below q; outputs lag in_valid by one clock
`timescale 1ns/1ns
`default_nettype none

module power2round_unit (
    input  wire                  clk,
    input  wire                  reset_n,
    input  wire                  in_valid,
    input  wire                  in_first,
    input  wire p2r_pkg::coeff_t coeff,
    p2r_stream_if.source         out_stream
);

    import p2r_pkg::*;

    t0_enc_t low;
    logic    carry;

    // low D bits, centred range is -4095..4096
    assign low   = coeff[D-1:0];
    // above the bound t0 goes negative and t1 picks up one
    assign carry = (low > t0_enc_t'(T0_BOUND));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            out_stream.valid <= 1'b0;
            out_stream.first <= 1'b0;
        end else begin
            out_stream.valid <= in_valid;
            out_stream.first <= in_valid & in_first;
        end
    end

    // ------------------------------------------------------------------
    // payload
    // ------------------------------------------------------------------
    // 4096 - t0 taken mod 2^D gives the same code for both branches
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_stream.t1     <= t1_t'(coeff[COEFF_W-1:D]) + t1_t'(carry);
            out_stream.t0_enc <= t0_enc_t'(T0_BOUND) - low;
        end
    end

endmodule

`default_nettype wire

// ==== src/sk_packer.sv ====
// secret-key word store; zeroize clears lane and address but keeps the stored words
`timescale 1ns/1ns
`default_nettype none

module sk_packer (
    input  wire                   clk,
    input  wire                   reset_n,
    input  wire                   zeroize,
    p2r_stream_if.sink            in_stream,
    input  wire p2r_pkg::sk_addr_t rd_addr,
    output p2r_pkg::sk_word_t     rd_data
);

    import p2r_pkg::*;

    logic     lane;
    sk_addr_t wr_addr;
    t0_enc_t  hold;
    sk_word_t mem [SK_WORDS];

    logic     cur_lane;
    sk_addr_t cur_addr;
    logic     wr_en;

    // first restarts the word and the address
    assign cur_lane = in_stream.first ? 1'b0 : lane;
    assign cur_addr = in_stream.first ? '0 : wr_addr;
    // word completes on the last lane
    assign wr_en    = in_stream.valid && !zeroize && (cur_lane == 1'(SK_PER_WORD - 1));

    // ------------------------------------------------------------------
    // lane and address counters
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            lane    <= 1'b0;
            wr_addr <= '0;
        end else if (zeroize) begin
            lane    <= 1'b0;
            wr_addr <= '0;
        end else if (in_stream.valid) begin
            if (wr_en) begin
                lane    <= 1'b0;
                wr_addr <= cur_addr + 1'b1;
            end else begin
                lane    <= cur_lane + 1'b1;
                wr_addr <= cur_addr;
            end
        end
    end

    // pending even coefficient
    always_ff @(posedge clk) begin
        if (in_stream.valid && !wr_en) begin
            hold <= in_stream.t0_enc;
        end
    end

    // ------------------------------------------------------------------
    // storage and readback
    // ------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[cur_addr] <= {in_stream.t0_enc, hold};
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== src/pk_packer.sv ====
// public-key word store of four t1 values; zeroize clears lane and address but keeps the stored words
`timescale 1ns/1ns
`default_nettype none

module pk_packer (
    input  wire                   clk,
    input  wire                   reset_n,
    input  wire                   zeroize,
    p2r_stream_if.sink            in_stream,
    input  wire p2r_pkg::pk_addr_t rd_addr,
    output p2r_pkg::pk_word_t     rd_data
);

    import p2r_pkg::*;

    logic [1:0] lane;
    pk_addr_t   wr_addr;
    t1_t        hold [PK_PER_WORD-1];
    pk_word_t   mem [PK_WORDS];

    logic [1:0] cur_lane;
    pk_addr_t   cur_addr;
    logic       wr_en;

    assign cur_lane = in_stream.first ? 2'd0 : lane;
    assign cur_addr = in_stream.first ? '0 : wr_addr;
    // fourth lane closes the word
    assign wr_en    = in_stream.valid && !zeroize && (cur_lane == 2'(PK_PER_WORD - 1));

    // ------------------------------------------------------------------
    // lane and address counters
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            lane    <= 2'd0;
            wr_addr <= '0;
        end else if (zeroize) begin
            lane    <= 2'd0;
            wr_addr <= '0;
        end else if (in_stream.valid) begin
            if (wr_en) begin
                lane    <= 2'd0;
                wr_addr <= cur_addr + 1'b1;
            end else begin
                lane    <= cur_lane + 2'd1;
                wr_addr <= cur_addr;
            end
        end
    end

    // lanes 0..2 wait here for the fourth
    always_ff @(posedge clk) begin
        if (in_stream.valid && !wr_en) begin
            hold[cur_lane] <= in_stream.t1;
        end
    end

    // ------------------------------------------------------------------
    // storage and readback
    // ------------------------------------------------------------------
    // lowest coefficient lands in bits 9..0
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[cur_addr] <= {in_stream.t1, hold[2], hold[1], hold[0]};
        end
    end

    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== src/power2round_ctrl.sv ====
// four-phase req/ack control; a new req is taken only once ack is low, zeroize aborts the run
`timescale 1ns/1ns
`default_nettype none

module power2round_ctrl (
    input  wire                    clk,
    input  wire                    reset_n,
    input  wire                    zeroize,
    input  wire                    req,
    output logic                   ack,
    output logic                   rd_en,
    output p2r_pkg::coeff_addr_t   rd_addr,
    output logic                   unit_valid,
    output logic                   unit_first
);

    import p2r_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    coeff_addr_t addr;
    logic [1:0]  drain_cnt;
    logic        last_addr;
    logic        drain_done;

    assign last_addr  = (addr == coeff_addr_t'(NUM_COEFF - 1));
    assign drain_done = (drain_cnt == 2'(DRAIN_CYCLES - 1));

    // ------------------------------------------------------------------
    // state machine
    // ------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                // ack still high means the last handshake has not closed
                if (req && !ack) begin
                    state_nxt = READ;
                end
            end
            READ: begin
                if (last_addr) begin
                    state_nxt = DRAIN;
                end
            end
            DRAIN: begin
                if (drain_done) begin
                    state_nxt = ACK;
                end
            end
            ACK: begin
                if (!req) begin
                    state_nxt = IDLE;
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= IDLE;
        end else if (zeroize) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // ------------------------------------------------------------------
    // counters, pipeline alignment and ack
    // ------------------------------------------------------------------
    // address wraps back to 0 after the last read
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            addr       <= '0;
            drain_cnt  <= 2'd0;
            unit_valid <= 1'b0;
            unit_first <= 1'b0;
            ack        <= 1'b0;
        end else if (zeroize) begin
            addr       <= '0;
            drain_cnt  <= 2'd0;
            unit_valid <= 1'b0;
            unit_first <= 1'b0;
            ack        <= 1'b0;
        end else begin
            addr       <= (state == READ) ? addr + 1'b1 : '0;
            drain_cnt  <= (state == DRAIN) ? drain_cnt + 2'd1 : 2'd0;
            // line up with the memory read data
            unit_valid <= rd_en;
            unit_first <= rd_en && (addr == '0);
            ack        <= (state == ACK);
        end
    end

    assign rd_en   = (state == READ);
    assign rd_addr = addr;

endmodule

`default_nettype wire

// ==== src/power2round_top.sv ====
// power2round top; load and readback ports are only meaningful while no run is in progress
`timescale 1ns/1ns
`default_nettype none

module power2round_top (
    input  wire                        clk,
    input  wire                        reset_n,
    input  wire                        zeroize,
    input  wire                        req,
    output logic                       ack,
    input  wire                        load_en,
    input  wire p2r_pkg::coeff_addr_t  load_addr,
    input  wire p2r_pkg::coeff_t       load_data,
    input  wire p2r_pkg::sk_addr_t     sk_rd_addr,
    output p2r_pkg::sk_word_t          sk_rd_data,
    input  wire p2r_pkg::pk_addr_t     pk_rd_addr,
    output p2r_pkg::pk_word_t          pk_rd_data
);

    import p2r_pkg::*;

    logic        rd_en;
    coeff_addr_t rd_addr;
    coeff_t      rd_data;
    logic        unit_valid;
    logic        unit_first;

    p2r_stream_if split_stream ();

    power2round_ctrl i_ctrl (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize    (zeroize),
        .req        (req),
        .ack        (ack),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .unit_valid (unit_valid),
        .unit_first (unit_first)
    );

    coeff_mem i_coeff_mem (
        .clk       (clk),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    power2round_unit i_unit (
        .clk        (clk),
        .reset_n    (reset_n),
        .in_valid   (unit_valid),
        .in_first   (unit_first),
        .coeff      (rd_data),
        .out_stream (split_stream)
    );

    // both packers take the same stream
    sk_packer i_sk_packer (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize   (zeroize),
        .in_stream (split_stream),
        .rd_addr   (sk_rd_addr),
        .rd_data   (sk_rd_data)
    );

    pk_packer i_pk_packer (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize   (zeroize),
        .in_stream (split_stream),
        .rd_addr   (pk_rd_addr),
        .rd_data   (pk_rd_data)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_clock_gen.sv ====
// free-running 4 ns clock; reset_n is held low for five rising edges and released on a falling edge
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset_n
);

    localparam int HALF_PERIOD  = 2;
    localparam int RESET_CYCLES = 5;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
    end

endmodule

`default_nettype wire

// ==== testbench/power2round_tb.sv ====
// random and boundary runs checked against a split model; stops at the first mismatch or timeout
`timescale 1ns/1ns
`default_nettype none

module power2round_tb;

    import p2r_pkg::*;

    localparam int ACK_TIMEOUT   = NUM_COEFF + 20;
    localparam int RESET_TIMEOUT = 20;
    localparam int IDLE_CYCLES   = 10;

    logic        clk;
    logic        reset_n;
    logic        zeroize;
    logic        req;
    logic        ack;
    logic        load_en;
    coeff_addr_t load_addr;
    coeff_t      load_data;
    sk_addr_t    sk_rd_addr;
    sk_word_t    sk_rd_data;
    pk_addr_t    pk_rd_addr;
    pk_word_t    pk_rd_data;

    coeff_t      model [NUM_COEFF];

    tb_clock_gen i_clock_gen (
        .clk     (clk),
        .reset_n (reset_n)
    );

    power2round_top i_power2round_top (
        .clk        (clk),
        .reset_n    (reset_n),
        .zeroize    (zeroize),
        .req        (req),
        .ack        (ack),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .sk_rd_addr (sk_rd_addr),
        .sk_rd_data (sk_rd_data),
        .pk_rd_addr (pk_rd_addr),
        .pk_rd_data (pk_rd_data)
    );

    // ------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------
    // t mod 2^13 moved into -4095..4096
    function automatic int centred_t0(input coeff_t c);
        int r;
        r = int'(c) % (1 << D);
        if (r > (1 << (D - 1))) begin
            r = r - (1 << D);
        end
        return r;
    endfunction

    function automatic sk_word_t expected_sk(input int word);
        sk_word_t w;
        int       t0;
        w = '0;
        for (int k = 0; k < SK_PER_WORD; k++) begin
            t0 = centred_t0(model[word * SK_PER_WORD + k]);
            w[k*D +: D] = t0_enc_t'((1 << (D - 1)) - t0);
        end
        return w;
    endfunction

    function automatic pk_word_t expected_pk(input int word);
        pk_word_t w;
        coeff_t   c;
        w = '0;
        for (int k = 0; k < PK_PER_WORD; k++) begin
            c = model[word * PK_PER_WORD + k];
            w[k*T1_W +: T1_W] = t1_t'((int'(c) - centred_t0(c)) / (1 << D));
        end
        return w;
    endfunction

    // ------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------
    task automatic stop_with_failure();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_sk(input sk_addr_t addr, input sk_word_t got, input sk_word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: sk_rd_data[%0d] got %h expected %h",
                     $time, addr, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_pk(input pk_addr_t addr, input pk_word_t got, input pk_word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: pk_rd_data[%0d] got %h expected %h",
                     $time, addr, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_ack(input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: ack got %b expected %b", $time, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_cycles(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    // ------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------
    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (!reset_n) begin
            @(negedge clk);
            cycles++;
            if (cycles > RESET_TIMEOUT) begin
                $display("reset was never released");
                stop_with_failure();
            end
        end
    endtask

    task automatic fill_random();
        for (int i = 0; i < NUM_COEFF; i++) begin
            model[i] = coeff_t'($urandom_range(Q - 1, 0));
        end
    endtask

    // edges of the centring rule, random high bits kept below q
    task automatic fill_boundary();
        fill_random();
        model[0] = '0;
        model[1] = coeff_t'(Q - 1);
        model[2] = coeff_t'($urandom_range(1022, 0) * (1 << D) + 4095);
        model[3] = coeff_t'($urandom_range(1022, 0) * (1 << D) + 4096);
        model[4] = coeff_t'($urandom_range(1022, 0) * (1 << D) + 4097);
        model[5] = coeff_t'($urandom_range(1022, 0) * (1 << D) + 8191);
        model[NUM_COEFF - 1] = coeff_t'(1022 * (1 << D) + 8191);
    endtask

    task automatic load_coeffs();
        for (int i = 0; i < NUM_COEFF; i++) begin
            load_en   = 1'b1;
            load_addr = coeff_addr_t'(i);
            load_data = model[i];
            @(negedge clk);
        end
        load_en = 1'b0;
    endtask

    // full four-phase handshake, req held for extra cycles once ack is up
    task automatic run_handshake(input int hold_cycles);
        int cycles;
        cycles = 0;
        req = 1'b1;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > ACK_TIMEOUT) begin
                $display("ack did not rise within %0d cycles of req", ACK_TIMEOUT);
                stop_with_failure();
            end
        end while (!ack);
        // sampling edge plus NUM_COEFF + 4
        check_cycles("ack rise latency", cycles, NUM_COEFF + 5);
        for (int i = 0; i < hold_cycles; i++) begin
            @(negedge clk);
            check_ack(ack, 1'b1);
        end
        req = 1'b0;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > ACK_TIMEOUT) begin
                $display("ack did not fall within %0d cycles of req going low", ACK_TIMEOUT);
                stop_with_failure();
            end
        end while (ack);
        // edge that samples req low, then one more
        check_cycles("ack fall latency", cycles, 2);
    endtask

    task automatic compare_keys();
        for (int a = 0; a < SK_WORDS; a++) begin
            sk_rd_addr = sk_addr_t'(a);
            @(negedge clk);
            check_sk(sk_addr_t'(a), sk_rd_data, expected_sk(a));
        end
        for (int a = 0; a < PK_WORDS; a++) begin
            pk_rd_addr = pk_addr_t'(a);
            @(negedge clk);
            check_pk(pk_addr_t'(a), pk_rd_data, expected_pk(a));
        end
    endtask

    task automatic full_random_run(input int hold_cycles);
        fill_random();
        load_coeffs();
        run_handshake(hold_cycles);
        compare_keys();
    endtask

    // ------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------
    initial begin
        int abort_at;
        void'($urandom(91));
        zeroize    = 1'b0;
        req        = 1'b0;
        load_en    = 1'b0;
        load_addr  = '0;
        load_data  = '0;
        sk_rd_addr = '0;
        pk_rd_addr = '0;

        wait_reset_release();
        @(negedge clk);

        // no request yet
        for (int i = 0; i < IDLE_CYCLES; i++) begin
            @(negedge clk);
            check_ack(ack, 1'b0);
        end

        full_random_run(0);

        fill_boundary();
        load_coeffs();
        run_handshake(0);
        compare_keys();

        // long req hold, then an ordinary run
        full_random_run($urandom_range(12, 1));
        full_random_run(0);

        // abort in the middle of READ
        fill_random();
        load_coeffs();
        abort_at = $urandom_range(NUM_COEFF - 2, 2);
        req = 1'b1;
        repeat (abort_at) @(negedge clk);
        zeroize = 1'b1;
        req     = 1'b0;
        @(negedge clk);
        zeroize = 1'b0;
        for (int i = 0; i < NUM_COEFF + 8; i++) begin
            @(negedge clk);
            check_ack(ack, 1'b0);
        end
        full_random_run(0);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
src/p2r_pkg.sv
src/p2r_stream_if.sv
src/coeff_mem.sv
src/power2round_unit.sv
src/sk_packer.sv
src/pk_packer.sv
src/power2round_ctrl.sv
src/power2round_top.sv
testbench/tb_clock_gen.sv
testbench/power2round_tb.sv

// ==== Makefile ====
# Verilator build of the power2round testbench

VERILATOR ?= verilator
TOP       ?= power2round_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ns -Wno-fatal -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status is nonzero when the testbench stops with $fatal
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
